//--- src/chan_acc_settings.svh
`ifndef CHAN_ACC_SETTINGS_SVH
`define CHAN_ACC_SETTINGS_SVH

// Pixels per feature map, also the depth of the partial-sum FIFO
`define CHAN_ACC_PIXELS 16

// Input channels per frame, two or more
`define CHAN_ACC_CHANNELS 4

// Index widths for the pixel and channel counters
`define CHAN_ACC_PIX_W ($clog2(`CHAN_ACC_PIXELS))
`define CHAN_ACC_CH_W ($clog2(`CHAN_ACC_CHANNELS))

`endif

//--- src/chan_acc_pkg.sv
package chan_acc_pkg;

  ////////////////////////////////////////////////////////////
  // Single-precision word, raw or split into fields
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] fraction;
  } fp32_fields_t;

  typedef union packed {
    logic [31:0]  word;
    fp32_fields_t f;
  } fp32_t;

  // Which input channel of the frame is streaming in
  typedef enum logic [1:0] {
    PHASE_FIRST  = 2'd0,
    PHASE_MIDDLE = 2'd1,
    PHASE_LAST   = 2'd2
  } acc_phase_t;

endpackage

//--- src/pixel_channel_counter.sv
`include "chan_acc_settings.svh"

module pixel_channel_counter (
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  output logic map_end,
  output logic frame_end
);

  localparam int PIX_W = `CHAN_ACC_PIX_W;
  localparam int CH_W = `CHAN_ACC_CH_W;
  localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(`CHAN_ACC_PIXELS - 1);
  localparam logic [CH_W-1:0] CH_LAST = CH_W'(`CHAN_ACC_CHANNELS - 1);

  logic [PIX_W-1:0] pix_idx;
  logic [CH_W-1:0]  ch_idx;

  // Flags qualified by the strobe itself
  assign map_end = valid_in && (pix_idx == PIX_LAST);
  assign frame_end = map_end && (ch_idx == CH_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_idx <= '0;
      ch_idx <= '0;
    end else if (valid_in) begin
      if (map_end) begin
        pix_idx <= '0;
        // Next map starts; wrap to channel 0 after the frame
        ch_idx <= frame_end ? '0 : ch_idx + 1'b1;
      end else begin
        pix_idx <= pix_idx + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_ch_in_range: assert property (@(posedge clk) disable iff (reset)
    ch_idx <= CH_LAST);

endmodule

//--- src/accumulate_control.sv
`include "chan_acc_settings.svh"

module accumulate_control import chan_acc_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic valid_in,
  input  logic map_end,
  input  logic frame_end,
  input  logic sum_valid,
  input  logic sum_last,
  output logic fifo_rd,
  output logic use_zero,
  output logic tag_last,
  output logic fifo_wr,
  output logic valid_out
);

  localparam int CH_W = `CHAN_ACC_CH_W;
  // Map index after which the last channel begins
  localparam logic [CH_W-1:0] PRE_LAST = CH_W'(`CHAN_ACC_CHANNELS - 2);

  acc_phase_t       phase;
  logic [CH_W-1:0]  map_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PHASE_FIRST;
      map_idx <= '0;
    end else if (map_end) begin
      if (frame_end) begin
        phase <= PHASE_FIRST;
        map_idx <= '0;
      end else begin
        map_idx <= map_idx + 1'b1;
        // Two-channel frames skip the middle phase
        phase <= (map_idx == PRE_LAST) ? PHASE_LAST : PHASE_MIDDLE;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Input side steering
  ////////////////////////////////////////////////////////////

  assign use_zero = (phase == PHASE_FIRST);
  assign tag_last = (phase == PHASE_LAST);
  assign fifo_rd = valid_in && (phase != PHASE_FIRST);

  // Adder output goes back to the FIFO or out of the block
  assign fifo_wr = sum_valid && !sum_last;
  assign valid_out = sum_valid && sum_last;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Own map count must agree with the pixel/channel counter
  a_last_map_ends_frame: assert property (@(posedge clk) disable iff (reset)
    (map_end && phase == PHASE_LAST) |-> frame_end);

  // Each result leaves by the phase its strobe saw two cycles earlier
  a_route_by_phase: assert property (@(posedge clk) disable iff (reset)
    sum_valid |-> (valid_out == $past(tag_last, 2)));

endmodule

//--- src/partial_sum_fifo.sv
`include "chan_acc_settings.svh"

module partial_sum_fifo import chan_acc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  wr,
  input  logic  rd,
  input  fp32_t din,
  output fp32_t dout,
  output logic  empty,
  output logic  full
);

  localparam int DEPTH = `CHAN_ACC_PIXELS;
  localparam int PTR_W = `CHAN_ACC_PIX_W;
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(DEPTH);

  fp32_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Head word is always presented
  assign dout = mem[rd_ptr];
  assign empty = (count == '0);
  assign full = (count == COUNT_FULL);

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (rd) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr, rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // A pop in the same cycle frees the slot being written
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    wr |-> (!full || rd));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd |-> !empty);

endmodule

//--- src/fp32_adder.sv
module fp32_adder import chan_acc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  valid_in,
  input  logic  use_zero,
  input  logic  tag_in,
  input  fp32_t a,
  input  fp32_t b,
  output logic  valid_out,
  output logic  tag_out,
  output fp32_t sum
);

  // Position of the first set bit, 24 when none
  function automatic logic [4:0] lead_zeros(input logic [23:0] v);
    logic [4:0] n;
    logic       found;
    n = 5'd24;
    found = 1'b0;
    for (int i = 23; i >= 0; i--) begin
      if (!found && v[i]) begin
        n = 5'(23 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stage 1: order by magnitude and align
  ////////////////////////////////////////////////////////////

  fp32_t       op_b;
  fp32_t       op_big;
  fp32_t       op_small;
  logic [23:0] man_big;
  logic [23:0] man_small;
  logic [7:0]  shift;

  always_comb begin
    op_b = use_zero ? '0 : b;
    if (a.word[30:0] < op_b.word[30:0]) begin
      op_big = op_b;
      op_small = a;
    end else begin
      op_big = a;
      op_small = op_b;
    end
    // Zero exponent reads as zero, denormals included
    man_big = (op_big.f.exponent == 8'd0) ? '0 : {1'b1, op_big.f.fraction};
    man_small = (op_small.f.exponent == 8'd0) ? '0 : {1'b1, op_small.f.fraction};
    shift = op_big.f.exponent - op_small.f.exponent;
  end

  logic        s1_valid;
  logic        s1_tag;
  logic        s1_sign;
  logic        s1_sub;
  logic [7:0]  s1_exp;
  logic [23:0] s1_man_big;
  logic [23:0] s1_man_small;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_tag <= 1'b0;
    end else begin
      s1_valid <= valid_in;
      s1_tag <= tag_in;
    end
  end

  always_ff @(posedge clk) begin
    s1_sign <= op_big.f.sign;
    s1_sub <= op_big.f.sign ^ op_small.f.sign;
    s1_exp <= op_big.f.exponent;
    s1_man_big <= man_big;
    s1_man_small <= man_small >> shift;
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: add, normalize, pack
  ////////////////////////////////////////////////////////////

  logic [24:0] raw;
  logic [4:0]  lz;
  logic [23:0] norm;
  fp32_t       result;

  always_comb begin
    if (s1_sub) begin
      raw = {1'b0, s1_man_big} - {1'b0, s1_man_small};
    end else begin
      raw = {1'b0, s1_man_big} + {1'b0, s1_man_small};
    end
    lz = lead_zeros(raw[23:0]);
    norm = raw[23:0] << lz;
    // Default +0 covers cancellation and underflow
    result = '0;
    if (raw[24]) begin
      result.f.sign = s1_sign;
      result.f.exponent = s1_exp + 8'd1;
      result.f.fraction = raw[23:1];
    end else if ((raw[23:0] != '0) && ({3'b000, lz} < s1_exp)) begin
      result.f.sign = s1_sign;
      result.f.exponent = s1_exp - {3'b000, lz};
      result.f.fraction = norm[22:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      tag_out <= 1'b0;
    end else begin
      valid_out <= s1_valid;
      tag_out <= s1_tag;
    end
  end

  always_ff @(posedge clk) begin
    sum <= result;
  end

endmodule

//--- src/chan_acc_top.sv
module chan_acc_top import chan_acc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  valid_in,
  input  fp32_t pxl_in,
  output fp32_t pxl_out,
  output logic  valid_out
);

  logic  map_end;
  logic  frame_end;
  logic  fifo_rd;
  logic  fifo_wr;
  logic  use_zero;
  logic  tag_last;
  logic  sum_valid;
  logic  sum_last;
  fp32_t fifo_head;

  pixel_channel_counter u_counter (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .map_end  (map_end),
    .frame_end(frame_end)
  );

  accumulate_control u_control (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .map_end  (map_end),
    .frame_end(frame_end),
    .sum_valid(sum_valid),
    .sum_last (sum_last),
    .fifo_rd  (fifo_rd),
    .use_zero (use_zero),
    .tag_last (tag_last),
    .fifo_wr  (fifo_wr),
    .valid_out(valid_out)
  );

  // Running sums for one map; the adder result feeds both FIFO and output
  partial_sum_fifo u_fifo (
    .clk  (clk),
    .reset(reset),
    .wr   (fifo_wr),
    .rd   (fifo_rd),
    .din  (pxl_out),
    .dout (fifo_head),
    .empty(),
    .full ()
  );

  fp32_adder u_adder (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .use_zero (use_zero),
    .tag_in   (tag_last),
    .a        (pxl_in),
    .b        (fifo_head),
    .valid_out(sum_valid),
    .tag_out  (sum_last),
    .sum      (pxl_out)
  );

endmodule

//--- bench/chan_acc_tb.sv
`include "chan_acc_settings.svh"

module chan_acc_tb import chan_acc_pkg::*;;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PIXELS = `CHAN_ACC_PIXELS;
  localparam int CHANNELS = `CHAN_ACC_CHANNELS;
  localparam int N_ROWS = 5;
  localparam int TOTAL_STROBES = N_ROWS * CHANNELS * PIXELS;
  localparam int WATCHDOG_NS = TOTAL_STROBES * 8 * 4 + 2000;
  localparam int DRAIN_CYCLES = 20;

  logic  clk = 1'b0;
  logic  reset;
  logic  valid_in;
  fp32_t pxl_in;
  fp32_t pxl_out;
  logic  valid_out;

  // One row per frame: frame number, gap mode, value per channel and pixel
  int row_frame [N_ROWS];
  bit row_gaps [N_ROWS];
  int row_val [N_ROWS][CHANNELS][PIXELS];

  fp32_t exp_q [$];
  int    due_q [$];
  int    cycle = 0;
  int    value_errors = 0;
  int    other_errors = 0;
  logic  exp_valid;

  chan_acc_top UUT (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .pxl_out  (pxl_out),
    .valid_out(valid_out)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Exact single-precision pattern of an integer below 2^24 in magnitude
  function automatic fp32_t to_fp32(input int v);
    fp32_t r;
    int    mag;
    int    e;
    r = '0;
    if (v == 0) begin
      return r;
    end
    mag = (v < 0) ? -v : v;
    e = 0;
    for (int i = 0; i < 31; i++) begin
      if (mag >= (1 << i)) begin
        e = i;
      end
    end
    r.f.sign = (v < 0);
    r.f.exponent = 8'(127 + e);
    r.f.fraction = 23'((mag << (23 - e)) & 32'h007f_ffff);
    return r;
  endfunction

  function automatic int pixel_sum(input int r, input int p);
    int s;
    s = 0;
    for (int c = 0; c < CHANNELS; c++) begin
      s += row_val[r][c][p];
    end
    return s;
  endfunction

  task automatic fill_table();
    for (int r = 0; r < N_ROWS; r++) begin
      row_frame[r] = r;
      // Frames 2 and 4 get random idle cycles between strobes
      row_gaps[r] = (r == 2) || (r == 4);
      for (int c = 0; c < CHANNELS; c++) begin
        for (int p = 0; p < PIXELS; p++) begin
          case (r)
            0: row_val[r][c][p] = p + 1 + c * PIXELS;
            1: row_val[r][c][p] = (c % 2 == 0) ? (p * 3 - c) : -(p + c);
            2: row_val[r][c][p] = int'($urandom_range(0, 200)) - 100;
            // Pairs of opposite sign cancel to zero
            3: row_val[r][c][p] = ((c % 2 == 0) ? 1 : -1) * (p + 1 + (c / 2) * 50);
            default: begin
              if (c == 0) row_val[r][c][p] = 1 << 22;
              else if (c == 1) row_val[r][c][p] = p - 8;
              else if (c % 2 == 0) row_val[r][c][p] = -(1 << (p + 4));
              else row_val[r][c][p] = 1 << (p % 8 + 12);
            end
          endcase
        end
      end
    end
  endtask

  task automatic check_word(input string name, input fp32_t expected, input fp32_t actual);
    if (actual.word !== expected.word) begin
      value_errors++;
      $display("FAILED at %0t: %s expected %h, got %h",
               $time, name, expected.word, actual.word);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic send_pixel(input int v, input bit last, input int sum, input bit gaps);
    int idle;
    @(posedge clk);
    valid_in <= 1'b1;
    pxl_in <= to_fp32(v);
    if (last) begin
      exp_q.push_back(to_fp32(sum));
      // Strobe is taken on the next edge and the sum comes two edges later
      due_q.push_back(cycle + 3);
    end
    idle = gaps ? int'($urandom_range(0, 3)) : 0;
    repeat (idle) begin
      @(posedge clk);
      valid_in <= 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
    check_bit("valid_out", exp_valid, valid_out);
    if (exp_valid) begin
      check_word("pxl_out", exp_q.pop_front(), pxl_out);
      void'(due_q.pop_front());
    end
  end

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("Watchdog expired with %0d sums still outstanding", exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int waited;
    void'($urandom(32'h6eee_2cde));
    reset = 1'b1;
    valid_in = 1'b0;
    pxl_in = '0;
    fill_table();
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    for (int r = 0; r < N_ROWS; r++) begin
      $display("Sending frame %0d", row_frame[r]);
      for (int c = 0; c < CHANNELS; c++) begin
        for (int p = 0; p < PIXELS; p++) begin
          send_pixel(row_val[r][c][p], c == CHANNELS - 1, pixel_sum(r, p), row_gaps[r]);
        end
      end
    end
    @(posedge clk);
    valid_in <= 1'b0;

    waited = 0;
    while ((exp_q.size() != 0) && (waited < DRAIN_CYCLES)) begin
      @(posedge clk);
      waited++;
    end
    // Quiet tail, no stray valid_out allowed
    repeat (6) @(posedge clk);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected sums never came out of the DUT", exp_q.size());
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+src
src/chan_acc_pkg.sv
src/pixel_channel_counter.sv
src/accumulate_control.sv
src/partial_sum_fifo.sv
src/fp32_adder.sv
src/chan_acc_top.sv
bench/chan_acc_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP = chan_acc_tb
FILELIST = all.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
